// ==== rtl/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    localparam int FLIT_WIDTH  = 64;
    localparam int RB_AWIDTH   = 12;
    localparam int QID_WIDTH   = 4;
    localparam int MAX_BURST   = 8;
    localparam int FIFO_AWIDTH = 6;

    // marks a completely written packet for the host driver
    localparam logic [FLIT_WIDTH-1:0] SIGNATURE = 64'h5ca1_ab1e_f1a9_d00d;

    typedef logic [FLIT_WIDTH-1:0] flit_data_t;
    typedef logic [RB_AWIDTH-1:0]  rb_ptr_t;
    typedef logic [QID_WIDTH-1:0]  qid_t;
    typedef logic [63:0]           host_addr_t;
    typedef logic [3:0]            burst_len_t;

    typedef struct packed {
        logic       sop;
        logic       eop;
        flit_data_t data;
    } flit_t;

    // size counts flits, not bytes
    typedef struct packed {
        qid_t    queue_id;
        rb_ptr_t size;
    } pkt_desc_t;

    typedef struct packed {
        rb_ptr_t    head;
        rb_ptr_t    tail;
        host_addr_t buf_addr;
    } queue_state_t;

    typedef struct packed {
        host_addr_t address;
        flit_data_t writedata;
        burst_len_t burstcount;
        logic       write;
    } bus_req_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        START_BURST,
        COMPLETE_BURST,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/flit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
    parameter int DWIDTH      = dma_pkg::FLIT_WIDTH,
    parameter int FIFO_AWIDTH = dma_pkg::FIFO_AWIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [DWIDTH-1:0]      wr_data,
    input  logic                   wr_en,
    output logic [DWIDTH-1:0]      rd_data,
    input  logic                   rd_en,
    output logic [FIFO_AWIDTH:0]   occup
);

    logic [DWIDTH-1:0]      mem [2**FIFO_AWIDTH];
    logic [FIFO_AWIDTH-1:0] wr_ptr;
    logic [FIFO_AWIDTH-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // head entry is visible without a read cycle
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occup  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   occup <= occup + 1'b1;
                2'b01:   occup <= occup - 1'b1;
                default: occup <= occup;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ring_space.sv ====
`timescale 1ns/1ps
`default_nettype none

module ring_space (
    input  dma_pkg::rb_ptr_t    head,
    input  dma_pkg::rb_ptr_t    tail,
    input  dma_pkg::rb_ptr_t    ring_size,
    input  dma_pkg::rb_ptr_t    missing,
    output dma_pkg::rb_ptr_t    free_slots,
    output dma_pkg::burst_len_t burst,
    output dma_pkg::rb_ptr_t    tail_plus_one
);

    dma_pkg::rb_ptr_t to_end;
    dma_pkg::rb_ptr_t limit;

    // one slot stays empty so that head == tail always means an empty ring
    always_comb begin
        if (tail >= head) begin
            free_slots = ring_size - tail + head - 1'b1;
        end else begin
            free_slots = head - tail - 1'b1;
        end
    end

    // slots left before the ring wraps
    assign to_end = ring_size - tail;

    always_comb begin
        limit = dma_pkg::rb_ptr_t'(dma_pkg::MAX_BURST);
        if (missing < limit) begin
            limit = missing;
        end
        if (to_end < limit) begin
            limit = to_end;
        end
        burst = dma_pkg::burst_len_t'(limit);
    end

    assign tail_plus_one = (tail == ring_size - 1'b1) ? '0 : tail + 1'b1;

endmodule

`default_nettype wire

// ==== rtl/host_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_write_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sw_reset,
    input  dma_pkg::bus_req_t   req,
    input  logic                req_valid,
    output logic                busy,
    input  logic                bus_waitrequest,
    output dma_pkg::host_addr_t bus_address,
    output dma_pkg::flit_data_t bus_writedata,
    output dma_pkg::burst_len_t bus_burstcount,
    output logic                bus_write,
    output logic [31:0]         stall_cnt
);

    // a beat still on the bus and not yet taken by the host
    assign busy = bus_write & bus_waitrequest;

    always_ff @(posedge clk) begin
        if (!busy && req_valid) begin
            bus_address    <= req.address;
            bus_writedata  <= req.writedata;
            bus_burstcount <= req.burstcount;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_write <= 1'b0;
            stall_cnt <= '0;
        end else begin
            // write falls after acceptance unless a new beat follows
            if (!busy) begin
                bus_write <= req_valid & req.write;
            end
            if (sw_reset) begin
                stall_cnt <= '0;
            end else if (busy) begin
                stall_cnt <= stall_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dma_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl #(
    parameter int FIFO_AWIDTH = dma_pkg::FIFO_AWIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sw_reset,
    input  dma_pkg::flit_t        pkt_head,
    output logic                  pkt_rd_en,
    input  logic [FIFO_AWIDTH:0]  pkt_occup,
    input  dma_pkg::pkt_desc_t    desc_head,
    output logic                  desc_rd_en,
    input  logic [FIFO_AWIDTH:0]  desc_occup,
    output logic                  queue_rd_en,
    output dma_pkg::qid_t         rd_queue,
    input  logic                  queue_ready,
    input  dma_pkg::queue_state_t queue_state,
    output logic                  tail_wr_en,
    output dma_pkg::qid_t         wr_queue,
    output dma_pkg::rb_ptr_t      out_tail,
    input  dma_pkg::rb_ptr_t      pkt_rb_size,
    output dma_pkg::bus_req_t     req,
    output logic                  req_valid,
    input  logic                  busy,
    output logic [31:0]           space_full_cnt
);

    dma_pkg::ctrl_state_t state;
    dma_pkg::qid_t        cur_qid;
    dma_pkg::flit_data_t  first_data;
    dma_pkg::rb_ptr_t     first_tail;
    dma_pkg::rb_ptr_t     tail;
    dma_pkg::host_addr_t  buf_addr;
    dma_pkg::rb_ptr_t     missing;
    dma_pkg::burst_len_t  beats_left;
    logic                 room;

    dma_pkg::rb_ptr_t     ring_tail;
    dma_pkg::rb_ptr_t     ring_free;
    dma_pkg::burst_len_t  ring_burst;
    dma_pkg::rb_ptr_t     ring_next;
    dma_pkg::rb_ptr_t     beat_ptr;

    // fetched tail is used directly while the queue state arrives
    assign ring_tail = (state == dma_pkg::FETCH) ? queue_state.tail : tail;
    assign beat_ptr  = (state == dma_pkg::DONE) ? first_tail : tail;

    ring_space u_ring_space (
        .head          (queue_state.head),
        .tail          (ring_tail),
        .ring_size     (pkt_rb_size),
        .missing       (missing),
        .free_slots    (ring_free),
        .burst         (ring_burst),
        .tail_plus_one (ring_next)
    );

    assign rd_queue = cur_qid;
    assign wr_queue = cur_qid;
    assign out_tail = tail;

    always_comb begin
        req        = '0;
        req_valid  = 1'b0;
        pkt_rd_en  = 1'b0;
        desc_rd_en = 1'b0;
        case (state)
            dma_pkg::IDLE: begin
                if (desc_occup != '0 && pkt_occup != '0) begin
                    desc_rd_en = 1'b1;
                    pkt_rd_en  = 1'b1;
                end
            end
            dma_pkg::START_BURST: begin
                if (!busy && room && (missing == '0 || pkt_occup != '0)) begin
                    req.address = buf_addr + (dma_pkg::host_addr_t'(beat_ptr) << 3);
                    req.write   = 1'b1;
                    req_valid   = 1'b1;
                    if (missing == '0) begin
                        req.writedata  = dma_pkg::SIGNATURE;
                        req.burstcount = 4'd1;
                    end else begin
                        req.writedata  = pkt_head.data;
                        req.burstcount = ring_burst;
                        pkt_rd_en      = 1'b1;
                    end
                end
            end
            dma_pkg::COMPLETE_BURST: begin
                // continuation beats carry no address and no count
                if (!busy && pkt_occup != '0) begin
                    req.writedata = pkt_head.data;
                    req.write     = 1'b1;
                    req_valid     = 1'b1;
                    pkt_rd_en     = 1'b1;
                end
            end
            dma_pkg::DONE: begin
                if (!busy && beats_left != '0) begin
                    req.address    = buf_addr + (dma_pkg::host_addr_t'(beat_ptr) << 3);
                    req.writedata  = first_data;
                    req.burstcount = 4'd1;
                    req.write      = 1'b1;
                    req_valid      = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= dma_pkg::IDLE;
            queue_rd_en    <= 1'b0;
            tail_wr_en     <= 1'b0;
            space_full_cnt <= '0;
            room           <= 1'b0;
            beats_left     <= '0;
        end else begin
            queue_rd_en <= 1'b0;
            tail_wr_en  <= 1'b0;
            if (sw_reset) begin
                space_full_cnt <= '0;
            end else if (state == dma_pkg::START_BURST && !busy && !room) begin
                space_full_cnt <= space_full_cnt + 1'b1;
            end
            case (state)
                dma_pkg::IDLE: begin
                    if (desc_rd_en) begin
                        queue_rd_en <= 1'b1;
                        state       <= dma_pkg::FETCH;
                    end
                end
                dma_pkg::FETCH: begin
                    if (queue_ready) begin
                        // first flit, rest of packet and signature must all fit
                        room  <= ring_free > missing + 1'b1;
                        state <= dma_pkg::START_BURST;
                    end
                end
                dma_pkg::START_BURST: begin
                    if (!busy && !room) begin
                        queue_rd_en <= 1'b1;
                        state       <= dma_pkg::FETCH;
                    end else if (req_valid && missing == '0) begin
                        beats_left <= 4'd1;
                        state      <= dma_pkg::DONE;
                    end else if (req_valid) begin
                        beats_left <= ring_burst - 1'b1;
                        if (ring_burst != 4'd1) begin
                            state <= dma_pkg::COMPLETE_BURST;
                        end
                    end
                end
                dma_pkg::COMPLETE_BURST: begin
                    if (req_valid) begin
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == 4'd1) begin
                            state <= dma_pkg::START_BURST;
                        end
                    end
                end
                dma_pkg::DONE: begin
                    if (req_valid) begin
                        beats_left <= '0;
                    end else if (!busy && beats_left == '0) begin
                        // the first flit has been accepted
                        tail_wr_en <= 1'b1;
                        state      <= dma_pkg::IDLE;
                    end
                end
                default: state <= dma_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (desc_rd_en) begin
            cur_qid    <= desc_head.queue_id;
            missing    <= desc_head.size - 1'b1;
            first_data <= pkt_head.data;
        end
        if (state == dma_pkg::FETCH && queue_ready) begin
            buf_addr   <= queue_state.buf_addr;
            first_tail <= queue_state.tail;
            tail       <= ring_next;
        end
        if (req_valid && state != dma_pkg::DONE) begin
            tail <= ring_next;
            if (missing != '0) begin
                missing <= missing - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fpga2cpu_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpga2cpu_dma #(
    parameter int FIFO_AWIDTH = dma_pkg::FIFO_AWIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sw_reset,

    input  dma_pkg::flit_t        pkt_wr_data,
    input  logic                  pkt_wr_en,
    output logic [FIFO_AWIDTH:0]  pkt_occup,

    input  dma_pkg::pkt_desc_t    desc_wr_data,
    input  logic                  desc_wr_en,
    output logic [FIFO_AWIDTH:0]  desc_occup,

    // queue state table
    output logic                  queue_rd_en,
    output dma_pkg::qid_t         rd_queue,
    input  logic                  queue_ready,
    input  dma_pkg::queue_state_t queue_state,
    output logic                  tail_wr_en,
    output dma_pkg::qid_t         wr_queue,
    output dma_pkg::rb_ptr_t      out_tail,
    input  dma_pkg::rb_ptr_t      pkt_rb_size,

    // host burst bus
    input  logic                  bus_waitrequest,
    output dma_pkg::host_addr_t   bus_address,
    output dma_pkg::flit_data_t   bus_writedata,
    output dma_pkg::burst_len_t   bus_burstcount,
    output logic                  bus_write,

    output logic [31:0]           dma_queue_full_cnt,
    output logic [31:0]           cpu_buf_full_cnt
);

    dma_pkg::flit_t     pkt_head;
    logic               pkt_rd_en;
    dma_pkg::pkt_desc_t desc_head;
    logic               desc_rd_en;
    dma_pkg::bus_req_t  req;
    logic               req_valid;
    logic               busy;

    flit_fifo #(
        .DWIDTH      ($bits(dma_pkg::flit_t)),
        .FIFO_AWIDTH (FIFO_AWIDTH)
    ) u_pkt_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_data (pkt_wr_data),
        .wr_en   (pkt_wr_en),
        .rd_data (pkt_head),
        .rd_en   (pkt_rd_en),
        .occup   (pkt_occup)
    );

    flit_fifo #(
        .DWIDTH      ($bits(dma_pkg::pkt_desc_t)),
        .FIFO_AWIDTH (FIFO_AWIDTH)
    ) u_desc_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_data (desc_wr_data),
        .wr_en   (desc_wr_en),
        .rd_data (desc_head),
        .rd_en   (desc_rd_en),
        .occup   (desc_occup)
    );

    dma_ctrl #(
        .FIFO_AWIDTH (FIFO_AWIDTH)
    ) u_dma_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .sw_reset       (sw_reset),
        .pkt_head       (pkt_head),
        .pkt_rd_en      (pkt_rd_en),
        .pkt_occup      (pkt_occup),
        .desc_head      (desc_head),
        .desc_rd_en     (desc_rd_en),
        .desc_occup     (desc_occup),
        .queue_rd_en    (queue_rd_en),
        .rd_queue       (rd_queue),
        .queue_ready    (queue_ready),
        .queue_state    (queue_state),
        .tail_wr_en     (tail_wr_en),
        .wr_queue       (wr_queue),
        .out_tail       (out_tail),
        .pkt_rb_size    (pkt_rb_size),
        .req            (req),
        .req_valid      (req_valid),
        .busy           (busy),
        .space_full_cnt (cpu_buf_full_cnt)
    );

    host_write_port u_host_write_port (
        .clk             (clk),
        .rst_n           (rst_n),
        .sw_reset        (sw_reset),
        .req             (req),
        .req_valid       (req_valid),
        .busy            (busy),
        .bus_waitrequest (bus_waitrequest),
        .bus_address     (bus_address),
        .bus_writedata   (bus_writedata),
        .bus_burstcount  (bus_burstcount),
        .bus_write       (bus_write),
        .stall_cnt       (dma_queue_full_cnt)
    );

endmodule

`default_nettype wire

// ==== test/fpga2cpu_dma_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpga2cpu_dma_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                bus_waitrequest,
    input dma_pkg::host_addr_t bus_address,
    input dma_pkg::flit_data_t bus_writedata,
    input dma_pkg::burst_len_t bus_burstcount,
    input logic                bus_write,
    input dma_pkg::flit_t      pkt_head,
    input logic                pkt_rd_en,
    input logic                desc_rd_en
);

    // a stalled beat stays on the bus unchanged
    a_hold_under_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bus_write && bus_waitrequest) |=>
            (bus_write && $stable(bus_address) && $stable(bus_writedata)
             && $stable(bus_burstcount))
    ) else $error("bus request changed while waitrequest was high");

    // descriptor pop takes the first flit of a packet
    a_first_flit_sop: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pkt_rd_en && desc_rd_en) |-> pkt_head.sop
    ) else $error("packet head popped with a descriptor had no sop");

    a_burst_limit: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_write |-> (bus_burstcount <= dma_pkg::burst_len_t'(dma_pkg::MAX_BURST))
    ) else $error("burstcount above the maximum burst");

endmodule

bind fpga2cpu_dma fpga2cpu_dma_properties u_fpga2cpu_dma_properties (
    .clk             (clk),
    .rst_n           (rst_n),
    .bus_waitrequest (bus_waitrequest),
    .bus_address     (bus_address),
    .bus_writedata   (bus_writedata),
    .bus_burstcount  (bus_burstcount),
    .bus_write       (bus_write),
    .pkt_head        (pkt_head),
    .pkt_rd_en       (pkt_rd_en),
    .desc_rd_en      (desc_rd_en)
);

`default_nettype wire

// ==== test/tb_fpga2cpu_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fpga2cpu_dma;

    localparam int CLK_PERIOD = 4;
    localparam int RING       = 64;
    localparam int NQUEUE     = 16;
    localparam int NROWS      = 6;
    localparam dma_pkg::host_addr_t BUF_BASE = 64'h1000;

    typedef struct packed {
        dma_pkg::qid_t    qid;
        dma_pkg::rb_ptr_t size;
        dma_pkg::rb_ptr_t head;
        dma_pkg::rb_ptr_t tail;
        logic             stall;
    } stim_row_t;

    // one packet per row and each row on its own queue
    localparam stim_row_t STIM [NROWS] = '{
        '{4'd1, 12'd1,  12'd0,  12'd0,  1'b0},
        '{4'd2, 12'd20, 12'd5,  12'd5,  1'b0},
        '{4'd3, 12'd12, 12'd50, 12'd58, 1'b0},  // wraps past slot 63
        '{4'd4, 12'd6,  12'd31, 12'd30, 1'b0},  // full until the head moves
        '{4'd5, 12'd30, 12'd10, 12'd10, 1'b1},
        '{4'd6, 12'd17, 12'd40, 12'd55, 1'b1}
    };

    logic                          clk;
    logic                          rst_n;
    logic                          sw_reset;
    dma_pkg::flit_t                pkt_wr_data;
    logic                          pkt_wr_en;
    logic [dma_pkg::FIFO_AWIDTH:0] pkt_occup;
    dma_pkg::pkt_desc_t            desc_wr_data;
    logic                          desc_wr_en;
    logic [dma_pkg::FIFO_AWIDTH:0] desc_occup;
    logic                          queue_rd_en;
    dma_pkg::qid_t                 rd_queue;
    logic                          queue_ready;
    dma_pkg::queue_state_t         queue_state;
    logic                          tail_wr_en;
    dma_pkg::qid_t                 wr_queue;
    dma_pkg::rb_ptr_t              out_tail;
    dma_pkg::rb_ptr_t              pkt_rb_size;
    logic                          bus_waitrequest;
    dma_pkg::host_addr_t           bus_address;
    dma_pkg::flit_data_t           bus_writedata;
    dma_pkg::burst_len_t           bus_burstcount;
    logic                          bus_write;
    logic [31:0]                   dma_queue_full_cnt;
    logic [31:0]                   cpu_buf_full_cnt;

    // queue table, host memory and bookkeeping of the bus model
    dma_pkg::queue_state_t queue_tbl [NQUEUE];
    dma_pkg::flit_data_t   host_mem [NQUEUE*RING];
    logic                  rand_wait;
    integer                seed = 93;
    int                    stall_seen = 0;
    int                    wr_count = 0;
    int                    last_idx = -1;

    fpga2cpu_dma #(
        .FIFO_AWIDTH (dma_pkg::FIFO_AWIDTH)
    ) u_fpga2cpu_dma (
        .clk(clk), .rst_n(rst_n), .sw_reset(sw_reset),
        .pkt_wr_data(pkt_wr_data), .pkt_wr_en(pkt_wr_en), .pkt_occup(pkt_occup),
        .desc_wr_data(desc_wr_data), .desc_wr_en(desc_wr_en), .desc_occup(desc_occup),
        .queue_rd_en(queue_rd_en), .rd_queue(rd_queue), .queue_ready(queue_ready),
        .queue_state(queue_state), .tail_wr_en(tail_wr_en), .wr_queue(wr_queue),
        .out_tail(out_tail), .pkt_rb_size(pkt_rb_size),
        .bus_waitrequest(bus_waitrequest), .bus_address(bus_address),
        .bus_writedata(bus_writedata), .bus_burstcount(bus_burstcount),
        .bus_write(bus_write),
        .dma_queue_full_cnt(dma_queue_full_cnt), .cpu_buf_full_cnt(cpu_buf_full_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(NROWS * 400 * CLK_PERIOD);
        $display("watchdog expired, the DMA did not finish its packets in time");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // queue, packet and flit index folded into the payload
    function automatic dma_pkg::flit_data_t flit_word(input dma_pkg::qid_t q, input int seq,
                                                      input int idx);
        return {16'hda7a, 12'h000, q, 16'(seq), 16'(idx)};
    endfunction

    function automatic dma_pkg::host_addr_t queue_base(input dma_pkg::qid_t q);
        return BUF_BASE + (dma_pkg::host_addr_t'(q) << 9);
    endfunction

    // host memory takes beats on write without waitrequest and tracks burst addresses
    initial begin : host_memory_model
        int idx;
        int next_idx;
        int burst_left;
        burst_left = 0;
        next_idx = 0;
        bus_waitrequest = 1'b0;
        for (int i = 0; i < NQUEUE*RING; i++) begin
            host_mem[i] = {32'hbad0_f11e, 32'(i)};
        end
        forever begin
            @(negedge clk);
            if (bus_write && bus_waitrequest) begin
                stall_seen++;
            end
            if (bus_write && !bus_waitrequest) begin
                if (burst_left == 0) begin
                    idx = int'((bus_address - BUF_BASE) >> 3);
                    check_value(64'(idx >= 0 && idx < NQUEUE*RING), 64'd1, "address out of range");
                    check_value(64'(int'(bus_burstcount) != 0 &&
                                    int'(bus_burstcount) <= dma_pkg::MAX_BURST),
                                64'd1, "burstcount out of range");
                    check_value(64'((idx % RING) + int'(bus_burstcount) <= RING), 64'd1,
                                "burst crosses the end of the ring");
                    burst_left = int'(bus_burstcount);
                    next_idx = idx;
                end
                host_mem[next_idx] = bus_writedata;
                last_idx = next_idx;
                wr_count++;
                next_idx++;
                burst_left--;
            end
            @(posedge clk);
            #1;
            bus_waitrequest = rand_wait && (($random(seed) & 3) != 0);
        end
    end

    task automatic run_row(input int row);
        stim_row_t     r;
        int            n;
        int            t;
        int            h;
        int            free;
        int            base;
        int            exp_tail;
        int            wr_base;
        logic          full;
        logic          bumped;
        logic          done;
        logic          fetch_pend;
        dma_pkg::qid_t fq;
        logic [31:0]   full_base;
        r = STIM[row];
        n = int'(r.size);
        t = int'(r.tail);
        h = int'(r.head);
        base = int'(r.qid) * RING;
        exp_tail = (t + n + 1) % RING;
        // packet plus signature must fit with one slot kept empty
        free = (h - t - 1 + RING) % RING;
        full = free < n + 1;
        queue_tbl[r.qid] = '{head: r.head, tail: r.tail, buf_addr: queue_base(r.qid)};
        rand_wait = r.stall;
        wr_base = wr_count;
        full_base = cpu_buf_full_cnt;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            pkt_wr_en = 1'b1;
            pkt_wr_data = '{sop: (i == 0), eop: (i == n - 1), data: flit_word(r.qid, row, i)};
        end
        @(posedge clk);
        #1;
        pkt_wr_en = 1'b0;
        desc_wr_en = 1'b1;
        desc_wr_data = '{queue_id: r.qid, size: r.size};
        @(posedge clk);
        #1;
        desc_wr_en = 1'b0;
        bumped = 1'b0;
        done = 1'b0;
        fetch_pend = 1'b0;
        fq = '0;
        while (!done) begin
            @(negedge clk);
            if (queue_rd_en) begin
                check_value(64'(rd_queue), 64'(r.qid), "fetch of wrong queue");
                fetch_pend = 1'b1;
                fq = rd_queue;
            end
            if (tail_wr_en) begin
                check_value(64'(wr_queue), 64'(r.qid), "write-back to wrong queue");
                check_value(64'(out_tail), 64'(exp_tail), "written-back tail");
                queue_tbl[r.qid].tail = out_tail;
                done = 1'b1;
            end
            if (full && !bumped && cpu_buf_full_cnt >= full_base + 3) begin
                check_value(64'(wr_count - wr_base), 64'd0, "write into a full ring");
                // software drained the ring
                queue_tbl[r.qid].head = r.tail;
                bumped = 1'b1;
            end
            @(posedge clk);
            #1;
            queue_ready = fetch_pend;
            if (fetch_pend) begin
                queue_state = queue_tbl[fq];
            end
            fetch_pend = 1'b0;
        end
        for (int i = 0; i < n; i++) begin
            check_value(host_mem[base + (t + i) % RING], flit_word(r.qid, row, i),
                        "packet flit in host memory");
        end
        check_value(host_mem[base + (t + n) % RING], dma_pkg::SIGNATURE, "signature flit");
        check_value(64'(last_idx), 64'(base + t), "first flit was not the last write");
        check_value(64'(wr_count - wr_base), 64'(n + 1), "number of host writes");
        check_value(64'(cpu_buf_full_cnt > full_base), 64'(full), "ring full counter");
        check_value(64'(dma_queue_full_cnt), 64'(stall_seen), "waitrequest stall counter");
        check_value(64'(pkt_occup), 64'd0, "packet FIFO not drained");
        check_value(64'(desc_occup), 64'd0, "descriptor FIFO not drained");
    endtask

    initial begin : stimulus
        rst_n = 1'b0;
        sw_reset = 1'b0;
        pkt_wr_data = '0;
        pkt_wr_en = 1'b0;
        desc_wr_data = '0;
        desc_wr_en = 1'b0;
        queue_ready = 1'b0;
        queue_state = '0;
        pkt_rb_size = dma_pkg::rb_ptr_t'(RING);
        rand_wait = 1'b0;
        for (int i = 0; i < NQUEUE; i++) begin
            queue_tbl[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value(64'(bus_write), 64'd0, "bus_write after reset");
        check_value(64'(queue_rd_en), 64'd0, "queue_rd_en after reset");
        check_value(64'(tail_wr_en), 64'd0, "tail_wr_en after reset");
        check_value(64'(pkt_occup), 64'd0, "packet FIFO occupancy after reset");
        check_value(64'(desc_occup), 64'd0, "descriptor FIFO occupancy after reset");
        check_value(64'(dma_queue_full_cnt), 64'd0, "stall counter after reset");
        check_value(64'(cpu_buf_full_cnt), 64'd0, "ring full counter after reset");
        for (int row = 0; row < NROWS; row++) begin
            run_row(row);
        end
        rand_wait = 1'b0;
        check_value(64'(dma_queue_full_cnt != 0), 64'd1, "no waitrequest stall was seen");
        @(posedge clk);
        #1;
        sw_reset = 1'b1;
        @(posedge clk);
        #1;
        sw_reset = 1'b0;
        check_value(64'(dma_queue_full_cnt), 64'd0, "stall counter after sw_reset");
        check_value(64'(cpu_buf_full_cnt), 64'd0, "ring full counter after sw_reset");
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/dma_pkg.sv
rtl/flit_fifo.sv
rtl/ring_space.sv
rtl/host_write_port.sv
rtl/dma_ctrl.sv
rtl/fpga2cpu_dma.sv
test/fpga2cpu_dma_properties.sv
test/tb_fpga2cpu_dma.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 \
    --top-module tb_fpga2cpu_dma \
    -f filelist.f
./obj_dir/Vtb_fpga2cpu_dma
